/* cmd_seq_pkg.sv */
// constants and types for the command sequencer where a 256 byte memory caps a command at 2048 bits
package cmd_seq_pkg;

    localparam logic [7:0] VERSION = 8'h01;

    // register bank
    localparam int REG_COUNT = 16;

    // pattern memory
    localparam logic [15:0] MEM_BASE  = 16'd16;  // first bus address of the pattern
    localparam int          MEM_BYTES = 256;
    localparam int          MEM_AW    = 8;

    // register map
    localparam logic [15:0] ADDR_RESET        = 16'd0;  // write strobe
    localparam logic [15:0] ADDR_START        = 16'd1;  // write strobe and finish flag
    localparam logic [15:0] ADDR_CONF         = 16'd2;
    localparam logic [15:0] ADDR_SIZE_LO      = 16'd3;  // 2 bytes little endian
    localparam logic [15:0] ADDR_REPEAT_LO    = 16'd5;  // 4 bytes
    localparam logic [15:0] ADDR_START_REP_LO = 16'd9;
    localparam logic [15:0] ADDR_STOP_REP_LO  = 16'd11;

    // bits inside the conf register
    localparam int CONF_EN_EXT_BIT    = 0;
    localparam int CONF_MODE_LSB      = 1;  // two bits
    localparam int CONF_DIS_CLK_BIT   = 3;
    localparam int CONF_DIS_PULSE_BIT = 4;

    // line coding, one bit takes two halves
    typedef enum logic [1:0] {
        MODE_NRZ        = 2'd0,
        MODE_RSVD       = 2'd1,  // sent as NRZ
        MODE_MAN_IEEE   = 2'd2,  // ~bit then bit
        MODE_MAN_THOMAS = 2'd3   // bit then ~bit
    } out_mode_e;

    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_SEND = 2'd1,
        SEQ_DONE = 2'd2   // one cycle with the line low
    } seq_state_e;

endpackage

/* cmd_cfg_if.sv */
// configuration levels from register bank to sequencer which must stay static while a stream runs
`timescale 1ns/10ps

interface cmd_cfg_if;

    logic [15:0]            cmd_size;      // in bits
    logic [31:0]            repeat_count;  // body passes
    logic [15:0]            start_repeat;  // first body bit
    logic [15:0]            stop_repeat;   // suffix length in bits
    cmd_seq_pkg::out_mode_e out_mode;
    logic                   en_ext_start;
    logic                   dis_cmd_pulse;

    // register bank side
    modport src (
        output cmd_size, repeat_count, start_repeat, stop_repeat,
        output out_mode, en_ext_start, dis_cmd_pulse
    );

    // sequencer side
    modport dst (
        input cmd_size, repeat_count, start_repeat, stop_repeat,
        input out_mode, en_ext_start, dis_cmd_pulse
    );

endinterface

/* cmd_mem.sv */
// 256 byte pattern store with no reset whose contents are undefined until written
`timescale 1ns/10ps

module cmd_mem (
    input  logic                           CMD_CLK_IN,
    input  logic                           we,
    input  logic [cmd_seq_pkg::MEM_AW-1:0] waddr,
    input  logic [7:0]                     wdata,
    input  logic [cmd_seq_pkg::MEM_AW-1:0] raddr_a,
    input  logic [cmd_seq_pkg::MEM_AW-1:0] raddr_b,
    output logic [7:0]                     rdata_a,
    output logic [7:0]                     rdata_b
);

    logic [7:0] mem [cmd_seq_pkg::MEM_BYTES];

    always_ff @(posedge CMD_CLK_IN) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // old data on a read of the byte being written
    always_ff @(posedge CMD_CLK_IN) begin
        rdata_a <= mem[raddr_a];  // bus read-back
    end

    always_ff @(posedge CMD_CLK_IN) begin
        rdata_b <= mem[raddr_b];  // sequencer
    end

endmodule

/* cmd_reg_bank.sv */
// single clock bus slave whose read data follows one cycle after the address and where writes to 0 and 1 only strobe
`timescale 1ns/10ps

module cmd_reg_bank (
    input  logic                           CMD_CLK_IN,
    input  logic                           RST_CMD_CLK,
    input  logic [15:0]                    bus_add,
    input  logic [7:0]                     bus_data_in,
    input  logic                           bus_rd,
    input  logic                           bus_wr,
    input  logic                           done,
    input  logic [7:0]                     mem_rdata,
    output logic [7:0]                     bus_data_out,
    output logic                           soft_rst,
    output logic                           start,
    output logic                           mem_we,
    output logic [cmd_seq_pkg::MEM_AW-1:0] mem_waddr,
    output logic [7:0]                     mem_wdata,
    output logic [cmd_seq_pkg::MEM_AW-1:0] mem_raddr,
    output logic                           cmd_clk_en,
    output logic                           ext_start_enable,
    cmd_cfg_if.src                         cfg
);

    logic [7:0]                     regs [2:cmd_seq_pkg::REG_COUNT-1];  // 0 and 1 hold nothing
    logic                           wr_rst;
    logic                           wr_start;
    logic                           in_regs;
    logic                           in_mem;
    logic [15:0]                    mem_off;
    logic                           finish;
    logic                           rd_mem_q;    // range select delayed to meet mem_rdata
    logic [7:0]                     rd_reg_q;
    logic [cmd_seq_pkg::MEM_AW-1:0] raddr_hold;  // keeps the last read byte on the bus side

    assign wr_rst   = bus_wr && (bus_add == cmd_seq_pkg::ADDR_RESET);
    assign wr_start = bus_wr && (bus_add == cmd_seq_pkg::ADDR_START);
    assign in_regs  = (bus_add >= cmd_seq_pkg::ADDR_CONF) && (bus_add < 16'(cmd_seq_pkg::REG_COUNT));
    assign mem_off  = bus_add - cmd_seq_pkg::MEM_BASE;
    assign in_mem   = (bus_add >= cmd_seq_pkg::MEM_BASE) &&
                      (mem_off < 16'(cmd_seq_pkg::MEM_BYTES));

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || wr_rst) begin
            for (int i = 2; i < cmd_seq_pkg::REG_COUNT; i++) begin
                regs[i] <= 8'd0;
            end
            regs[cmd_seq_pkg::ADDR_REPEAT_LO] <= 8'd1;  // one pass by default
        end else if (bus_wr && in_regs) begin
            regs[bus_add[3:0]] <= bus_data_in;
        end
    end

    // strobes go out one cycle after the write
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            soft_rst <= 1'b0;
            start    <= 1'b0;
        end else begin
            soft_rst <= wr_rst;
            start    <= wr_start;
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || wr_rst) begin
            finish <= 1'b1;
        end else if (wr_start) begin
            finish <= 1'b0;
        end else if (done) begin
            finish <= 1'b1;
        end
    end

    assign cfg.cmd_size      = {regs[cmd_seq_pkg::ADDR_SIZE_LO + 16'd1],
                                regs[cmd_seq_pkg::ADDR_SIZE_LO]};
    assign cfg.repeat_count  = {regs[cmd_seq_pkg::ADDR_REPEAT_LO + 16'd3],
                                regs[cmd_seq_pkg::ADDR_REPEAT_LO + 16'd2],
                                regs[cmd_seq_pkg::ADDR_REPEAT_LO + 16'd1],
                                regs[cmd_seq_pkg::ADDR_REPEAT_LO]};
    assign cfg.start_repeat  = {regs[cmd_seq_pkg::ADDR_START_REP_LO + 16'd1],
                                regs[cmd_seq_pkg::ADDR_START_REP_LO]};
    assign cfg.stop_repeat   = {regs[cmd_seq_pkg::ADDR_STOP_REP_LO + 16'd1],
                                regs[cmd_seq_pkg::ADDR_STOP_REP_LO]};
    assign cfg.out_mode      = cmd_seq_pkg::out_mode_e'(
                                regs[cmd_seq_pkg::ADDR_CONF][cmd_seq_pkg::CONF_MODE_LSB +: 2]);
    assign cfg.en_ext_start  = regs[cmd_seq_pkg::ADDR_CONF][cmd_seq_pkg::CONF_EN_EXT_BIT];
    assign cfg.dis_cmd_pulse = regs[cmd_seq_pkg::ADDR_CONF][cmd_seq_pkg::CONF_DIS_PULSE_BIT];

    assign ext_start_enable = regs[cmd_seq_pkg::ADDR_CONF][cmd_seq_pkg::CONF_EN_EXT_BIT];
    assign cmd_clk_en       = ~regs[cmd_seq_pkg::ADDR_CONF][cmd_seq_pkg::CONF_DIS_CLK_BIT];

    // pattern memory ports
    assign mem_we    = bus_wr && in_mem;
    assign mem_waddr = mem_off[cmd_seq_pkg::MEM_AW-1:0];
    assign mem_wdata = bus_data_in;
    assign mem_raddr = bus_rd ? mem_off[cmd_seq_pkg::MEM_AW-1:0] : raddr_hold;

    always_ff @(posedge CMD_CLK_IN) begin
        raddr_hold <= mem_raddr;
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            rd_mem_q <= 1'b0;
            rd_reg_q <= 8'd0;
        end else if (bus_rd) begin
            rd_mem_q <= in_mem;
            if (bus_add == cmd_seq_pkg::ADDR_RESET) begin
                rd_reg_q <= cmd_seq_pkg::VERSION;
            end else if (bus_add == cmd_seq_pkg::ADDR_START) begin
                rd_reg_q <= {7'd0, finish};
            end else if (in_regs) begin
                rd_reg_q <= regs[bus_add[3:0]];
            end else begin
                rd_reg_q <= 8'd0;  // memory or unmapped
            end
        end
    end

    assign bus_data_out = rd_mem_q ? mem_rdata : rd_reg_q;

endmodule

/* cmd_sequencer.sv */
// needs 1 <= cmd_size <= 2048 and start_repeat <= cmd_size - stop_repeat while repeat_count 0 runs once and mode 1 is NRZ
`timescale 1ns/10ps

module cmd_sequencer (
    input  logic                           CMD_CLK_IN,
    input  logic                           RST_CMD_CLK,
    input  logic                           soft_rst,
    input  logic                           start,
    input  logic                           ext_start_flag,
    input  logic [7:0]                     seq_rdata,
    output logic [cmd_seq_pkg::MEM_AW-1:0] seq_raddr,
    output logic                           done,
    output logic                           cmd_data,
    output logic                           cmd_ready,
    output logic                           cmd_start_flag,
    cmd_cfg_if.dst                         cfg
);

    cmd_seq_pkg::seq_state_e state;

    logic        clr;
    logic        ext_go;      // external start lined up with the register start
    logic        go;
    logic        prime;       // first SEND cycle while byte 0 is read
    logic        active;
    logic        half;        // 0 first half, 1 second half
    logic [15:0] bit_idx;
    logic [31:0] pass;
    logic [31:0] pass_total;
    logic [15:0] body_end;
    logic [15:0] last_bit;
    logic        loop_back;
    logic [15:0] next_idx;
    logic        at_end;
    logic [12:0] rd_byte;
    logic        cur_bit;
    logic        half_val;

    assign clr        = RST_CMD_CLK | soft_rst;
    assign go         = start | ext_go;
    assign active     = (state == cmd_seq_pkg::SEQ_SEND) && !prime;
    assign done       = (state == cmd_seq_pkg::SEQ_DONE);

    assign pass_total = (cfg.repeat_count == 32'd0) ? 32'd1 : cfg.repeat_count;
    assign body_end   = cfg.cmd_size - cfg.stop_repeat - 16'd1;
    assign last_bit   = cfg.cmd_size - 16'd1;
    assign loop_back  = (bit_idx == body_end) && (pass < pass_total);
    assign next_idx   = loop_back ? cfg.start_repeat : bit_idx + 16'd1;
    assign at_end     = half && (bit_idx == last_bit) && !loop_back;

    // next byte is requested in the second half so it lands with the next bit
    assign rd_byte   = (active && half && !at_end) ? next_idx[15:3] : bit_idx[15:3];
    assign seq_raddr = rd_byte[cmd_seq_pkg::MEM_AW-1:0];

    assign cur_bit = seq_rdata[~bit_idx[2:0]];  // msb first

    always_comb begin
        case (cfg.out_mode)
            cmd_seq_pkg::MODE_MAN_IEEE:   half_val = half ? cur_bit : ~cur_bit;
            cmd_seq_pkg::MODE_MAN_THOMAS: half_val = half ? ~cur_bit : cur_bit;
            default:                      half_val = cur_bit;  // NRZ and reserved
        endcase
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (clr) begin
            ext_go <= 1'b0;
        end else begin
            ext_go <= ext_start_flag & cfg.en_ext_start;
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (clr) begin
            state   <= cmd_seq_pkg::SEQ_IDLE;
            prime   <= 1'b0;
            half    <= 1'b0;
            bit_idx <= 16'd0;
            pass    <= 32'd1;
        end else begin
            case (state)
                cmd_seq_pkg::SEQ_IDLE: begin
                    if (go) begin  // starts while busy fall here only in idle
                        state   <= cmd_seq_pkg::SEQ_SEND;
                        prime   <= 1'b1;
                        half    <= 1'b0;
                        bit_idx <= 16'd0;
                        pass    <= 32'd1;
                    end
                end
                cmd_seq_pkg::SEQ_SEND: begin
                    if (prime) begin
                        prime <= 1'b0;
                    end else begin
                        half <= ~half;
                        if (at_end) begin
                            state <= cmd_seq_pkg::SEQ_DONE;
                        end else if (half) begin
                            bit_idx <= next_idx;
                            if (loop_back) begin
                                pass <= pass + 32'd1;
                            end
                        end
                    end
                end
                default: begin
                    state <= cmd_seq_pkg::SEQ_IDLE;  // DONE lasts one cycle
                end
            endcase
        end
    end

    // line outputs trail the counters by one cycle
    always_ff @(posedge CMD_CLK_IN) begin
        if (clr) begin
            cmd_data       <= 1'b0;
            cmd_ready      <= 1'b1;
            cmd_start_flag <= 1'b0;
        end else begin
            cmd_data       <= active & half_val;  // low in prime and DONE
            cmd_ready      <= (state == cmd_seq_pkg::SEQ_IDLE);
            cmd_start_flag <= active && !half && (bit_idx == cfg.start_repeat) &&
                              (pass == 32'd1) && !cfg.dis_cmd_pulse;
        end
    end

    // pattern must fit the memory for the whole stream
    a_raddr_in_mem: assert property (@(posedge CMD_CLK_IN) disable iff (clr)
        (state == cmd_seq_pkg::SEQ_SEND) |-> (rd_byte < 13'(cmd_seq_pkg::MEM_BYTES)));

    // start flag marks only the first pass
    a_start_flag_single: assert property (@(posedge CMD_CLK_IN) disable iff (clr)
        cmd_start_flag |=> !cmd_start_flag);

    a_state_legal: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        state inside {cmd_seq_pkg::SEQ_IDLE, cmd_seq_pkg::SEQ_SEND, cmd_seq_pkg::SEQ_DONE});

endmodule

/* cmd_seq_top.sv */
// single clock top level where cmd_clk_en only flags clock gating and no clock is forwarded
`timescale 1ns/10ps

module cmd_seq_top (
    input  logic        CMD_CLK_IN,
    input  logic        RST_CMD_CLK,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_rd,
    input  logic        bus_wr,
    input  logic        ext_start_flag,
    output logic [7:0]  bus_data_out,
    output logic        ext_start_enable,
    output logic        cmd_clk_en,
    output logic        cmd_data,
    output logic        cmd_ready,
    output logic        cmd_start_flag
);

    logic                           soft_rst;
    logic                           start;
    logic                           done;
    logic                           mem_we;
    logic [cmd_seq_pkg::MEM_AW-1:0] mem_waddr;
    logic [7:0]                     mem_wdata;
    logic [cmd_seq_pkg::MEM_AW-1:0] mem_raddr;
    logic [7:0]                     mem_rdata;
    logic [cmd_seq_pkg::MEM_AW-1:0] seq_raddr;
    logic [7:0]                     seq_rdata;

    cmd_cfg_if cfg_if ();

    cmd_reg_bank cmd_reg_bank_inst (
        .CMD_CLK_IN       (CMD_CLK_IN),
        .RST_CMD_CLK      (RST_CMD_CLK),
        .bus_add          (bus_add),
        .bus_data_in      (bus_data_in),
        .bus_rd           (bus_rd),
        .bus_wr           (bus_wr),
        .done             (done),
        .mem_rdata        (mem_rdata),
        .bus_data_out     (bus_data_out),
        .soft_rst         (soft_rst),
        .start            (start),
        .mem_we           (mem_we),
        .mem_waddr        (mem_waddr),
        .mem_wdata        (mem_wdata),
        .mem_raddr        (mem_raddr),
        .cmd_clk_en       (cmd_clk_en),
        .ext_start_enable (ext_start_enable),
        .cfg              (cfg_if.src)
    );

    cmd_mem cmd_mem_inst (
        .CMD_CLK_IN (CMD_CLK_IN),
        .we         (mem_we),
        .waddr      (mem_waddr),
        .wdata      (mem_wdata),
        .raddr_a    (mem_raddr),
        .raddr_b    (seq_raddr),
        .rdata_a    (mem_rdata),
        .rdata_b    (seq_rdata)
    );

    cmd_sequencer cmd_sequencer_inst (
        .CMD_CLK_IN     (CMD_CLK_IN),
        .RST_CMD_CLK    (RST_CMD_CLK),
        .soft_rst       (soft_rst),
        .start          (start),
        .ext_start_flag (ext_start_flag),
        .seq_rdata      (seq_rdata),
        .seq_raddr      (seq_raddr),
        .done           (done),
        .cmd_data       (cmd_data),
        .cmd_ready      (cmd_ready),
        .cmd_start_flag (cmd_start_flag),
        .cfg            (cfg_if.dst)
    );

endmodule

/* cmd_seq_tb.sv */
// reads the trace file from the project root and needs patterns that fit the 256 byte memory
`timescale 1ns/10ps

module cmd_seq_tb;

    logic        CMD_CLK_IN;
    logic        RST_CMD_CLK;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    logic        ext_start_flag;
    logic [7:0]  bus_data_out;
    logic        ext_start_enable;
    logic        cmd_clk_en;
    logic        cmd_data;
    logic        cmd_ready;
    logic        cmd_start_flag;

    string test_name;
    int    errors;
    logic  exp_q [$];  // predicted halves
    logic  act_q [$];  // captured halves
    int    flag_pos;   // half index of the first start flag
    int    flag_cnt;

    cmd_seq_top cmd_seq_top_inst (.*);

    initial begin
        CMD_CLK_IN = 1'b0;
        forever #5 CMD_CLK_IN = ~CMD_CLK_IN;
    end

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge CMD_CLK_IN);
        #1;
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(posedge CMD_CLK_IN);  // edge that takes the write
        #1;
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge CMD_CLK_IN);
        #1;
        bus_add = addr;
        bus_rd  = 1'b1;
        @(posedge CMD_CLK_IN);
        #1;
        bus_rd = 1'b0;
        @(negedge CMD_CLK_IN);  // read data held from the sampling edge
        data = bus_data_out;
    endtask

    task automatic pulse_ext_start();
        @(posedge CMD_CLK_IN);
        #1;
        ext_start_flag = 1'b1;
        @(posedge CMD_CLK_IN);
        #1;
        ext_start_flag = 1'b0;
    endtask

    function automatic int bit_count(input string bits);
        int n;
        n = 0;
        for (int i = 0; i < bits.len(); i++) begin
            if (bits.getc(i) == "0" || bits.getc(i) == "1") begin
                n++;
            end
        end
        return n;
    endfunction

    // two halves per bit while underscores only group the bits
    task automatic predict_stream(input string bits, input int mode);
        logic b;
        exp_q.delete();
        for (int i = 0; i < bits.len(); i++) begin
            if (bits.getc(i) == "0" || bits.getc(i) == "1") begin
                b = (bits.getc(i) == "1");
                exp_q.push_back((mode == 2) ? ~b : b);  // ieee starts inverted
                exp_q.push_back((mode == 3) ? ~b : b);  // thomas ends inverted
            end
        end
    endtask

    task automatic capture_stream(input int halves);
        act_q.delete();
        flag_pos = -1;
        flag_cnt = 0;
        repeat (3) @(posedge CMD_CLK_IN);  // bit 0 from E+3
        for (int i = 0; i < halves; i++) begin
            @(negedge CMD_CLK_IN);
            if (i == 0) begin
                compare_value("cmd_ready during stream", 0, cmd_ready);
            end
            act_q.push_back(cmd_data);
            if (cmd_start_flag) begin
                flag_pos = (flag_pos < 0) ? i : flag_pos;
                flag_cnt++;
            end
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        do begin
            @(negedge CMD_CLK_IN);
            n++;
        end while (!cmd_ready && n < 10);
        compare_value("cmd_ready after stream", 1, cmd_ready);
        compare_value("cmd_data when ready", 0, cmd_data);
    endtask

    task automatic run_stream(input string kind, input int mode, input int flag,
                              input string bits);
        logic [7:0] rd_val;
        predict_stream(bits, mode);
        if (kind == "i") begin
            compare_value("ext_start_enable", 0, ext_start_enable);
            pulse_ext_start();
            repeat (10) begin
                @(negedge CMD_CLK_IN);
                compare_value("cmd_ready with external start off", 1, cmd_ready);
            end
            return;
        end
        if (kind == "x") begin
            compare_value("ext_start_enable", 1, ext_start_enable);
            pulse_ext_start();
        end else begin
            bus_write(cmd_seq_pkg::ADDR_START, 8'h00);
        end
        fork
            capture_stream(exp_q.size());
            if (kind == "b") begin
                repeat (12) @(posedge CMD_CLK_IN);  // restart lands mid stream
                bus_write(cmd_seq_pkg::ADDR_START, 8'h00);
            end
        join
        foreach (exp_q[i]) begin
            if (act_q[i] !== exp_q[i]) begin
                compare_value($sformatf("cmd_data half %0d", i), exp_q[i], act_q[i]);
                break;
            end
        end
        compare_value("start flag half", (flag < 0) ? -1 : 2 * flag, flag_pos);
        compare_value("start flag pulses", (flag < 0) ? 0 : 1, flag_cnt);
        if (kind == "s") begin
            bus_write(cmd_seq_pkg::ADDR_RESET, 8'h00);
            wait_ready();
        end else begin
            @(negedge CMD_CLK_IN);
            compare_value("cmd_data in done cycle", 0, cmd_data);
            wait_ready();
            bus_read(cmd_seq_pkg::ADDR_START, rd_val);
            compare_value("finish flag", 1, rd_val);
        end
    endtask

    initial begin
        int         fd;
        int         budget;
        int         tests;
        int         failed;
        int         test_errs;
        int         addr, data, mode, flag, ready, ext_en, clk_en;
        string      line, kw, kind, bits;
        string      lines [$];
        logic [7:0] rd_val;

        RST_CMD_CLK    = 1'b1;
        bus_add        = 16'd0;
        bus_data_in    = 8'd0;
        bus_rd         = 1'b0;
        bus_wr         = 1'b0;
        ext_start_flag = 1'b0;
        errors         = 0;
        tests          = 0;
        failed         = 0;
        test_errs      = 0;
        budget         = 200;
        test_name      = "none";

        fd = $fopen("cmd_seq_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file cmd_seq_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && $sscanf(line, "%s", kw) == 1 &&
                    kw.getc(0) != "#") begin
                    lines.push_back(line);
                    if (kw == "test") begin
                        budget += 20;
                    end else if (kw == "run") begin
                        void'($sscanf(line, "%s %s %d %d %s", kw, kind, mode, flag, bits));
                        budget += 2 * bit_count(bits);
                    end
                end
            end
            $fclose(fd);
        end

        fork
            begin
                repeat (budget) @(posedge CMD_CLK_IN);
                $display("timeout after %0d cycles, the sequencer never returned to ready",
                         budget);
                $display("Test failed");
                $finish;
            end
        join_none

        repeat (10) @(posedge CMD_CLK_IN);
        #1;
        RST_CMD_CLK = 1'b0;

        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s", kw));
            if (kw == "test") begin
                void'($sscanf(lines[i], "%s %s", kw, test_name));
                test_errs = errors;
            end else if (kw == "wr") begin
                void'($sscanf(lines[i], "%s %h %h", kw, addr, data));
                bus_write(addr[15:0], data[7:0]);
            end else if (kw == "rd") begin
                void'($sscanf(lines[i], "%s %h %h", kw, addr, data));
                bus_read(addr[15:0], rd_val);
                compare_value($sformatf("read of %04h", addr), data, rd_val);
            end else if (kw == "lvl") begin
                void'($sscanf(lines[i], "%s %d %d %d", kw, ready, ext_en, clk_en));
                @(negedge CMD_CLK_IN);
                compare_value("cmd_ready", ready, cmd_ready);
                compare_value("ext_start_enable", ext_en, ext_start_enable);
                compare_value("cmd_clk_en", clk_en, cmd_clk_en);
            end else if (kw == "run") begin
                void'($sscanf(lines[i], "%s %s %d %d %s", kw, kind, mode, flag, bits));
                run_stream(kind, mode, flag, bits);
            end else if (kw == "end") begin
                tests++;
                failed += (errors != test_errs);
                $display("%s: %s", test_name, (errors == test_errs) ? "passed" : "FAILED");
            end else begin
                $display("unknown trace keyword %s", kw);
                errors++;
            end
        end

        $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0 && tests > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* cmd_seq_trace.txt */
# test <name> | wr <addr> <data> | rd <addr> <expected> | lvl <ready> <ext_en> <clk_en> | end
# run <start: w write, x external, i external while off, b restart busy, s soft reset> <mode> <flag bit or -1> <bits>
test reset_readback
lvl 1 0 1
rd 0000 01
rd 0001 01
rd 0005 01
rd 0003 00
wr 0003 a5
rd 0003 a5
wr 000f 3c
rd 000f 3c
wr 0010 de
wr 0011 ad
rd 0010 de
rd 0011 ad
rd 0110 00
wr 0002 08
lvl 1 0 0
wr 0002 00
end
test nrz_single
wr 0010 b5
wr 0011 3c
wr 0012 a0
wr 0003 14
run w 0 0 10110101_00111100_1010
end
test repeat_body
wr 0009 04
wr 000b 03
wr 0005 03
run w 0 4 1011_0101001111001_0101001111001_0101001111001_010
end
test manchester_ieee
wr 0009 00
wr 000b 00
wr 0005 01
wr 0002 04
run w 2 0 10110101_00111100_1010
end
test manchester_thomas
wr 0002 06
run w 3 0 10110101_00111100_1010
end
test ext_start_off
wr 0002 00
run i 0 -1 -
end
test ext_start_on
wr 0002 01
run x 0 0 10110101_00111100_1010
end
test ext_start_no_pulse
wr 0002 11
run x 0 -1 10110101_00111100_1010
end
test start_while_busy
wr 0002 00
run b 0 0 10110101_00111100_1010
end
test soft_reset
wr 0005 07
run s 0 0 10110101
lvl 1 0 1
rd 0001 01
rd 0003 00
rd 0005 01
rd 0011 3c
end

/* cmd_seq.f */
cmd_seq_pkg.sv
cmd_cfg_if.sv
cmd_mem.sv
cmd_reg_bank.sv
cmd_sequencer.sv
cmd_seq_top.sv
cmd_seq_tb.sv

/* Bender.yml */
package:
  name: cmd_seq

sources:
  - cmd_seq_pkg.sv
  - cmd_cfg_if.sv
  - cmd_mem.sv
  - cmd_reg_bank.sv
  - cmd_sequencer.sv
  - cmd_seq_top.sv
  - target: test
    files:
      - cmd_seq_tb.sv
